//--- hdl/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data and PC width
`define XLEN 32

// Architectural register file
`define NREGS 32
`define REG_IDX_W 5

`define RESET_PC 32'h0000_1000

`endif

//--- hdl/isa_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0] xword_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [1:0] {
        OP_ALU,
        OP_BRANCH,
        OP_MUL
    } op_type_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {
        EQ,
        NE,
        LT,
        GE,
        LTU,
        GEU,
        ALWAYS
    } cond_e;

    // Instruction as delivered by the decoder
    typedef struct packed {
        xword_t   pc;
        op_type_e op_type;
        alu_op_e  alu_op;
        cond_e    cond;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        xword_t   imm;
        logic     use_imm;
    } decoded_instr_t;

endpackage

`default_nettype wire

//--- hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    typedef enum logic {
        ST_NORMAL,
        ST_MISPREDICT
    } ex_state_e;

    typedef enum logic {
        FU_ALU,
        FU_MUL
    } fu_sel_e;

    typedef enum logic [1:0] {
        BYP_RF,
        BYP_EX1,
        BYP_EX2
    } byp_sel_e;

    // Contents of the EX1/EX2 register
    typedef struct packed {
        op_type_e op_type;
        xword_t   pc;
        reg_idx_t rd;
        // ALU result or link value, rs1 for a multiply
        xword_t   value;
        // rs2 for a multiply
        xword_t   value2;
        logic     value_valid;
    } ex1_out_t;

endpackage

`default_nettype wire

//--- hdl/reg_file.sv
`default_nettype none

`include "cpu_params.svh"

module reg_file import isa_pkg::*; (
    input  wire logic     clk,
    input  wire logic     resetn,
    input  wire reg_idx_t i_rs1_idx,
    input  wire reg_idx_t i_rs2_idx,
    output xword_t        o_rs1_data,
    output xword_t        o_rs2_data,
    input  wire logic     i_we,
    input  wire reg_idx_t i_rd,
    input  wire xword_t   i_wdata
);

    xword_t regs [`NREGS];

    // x0 is hardwired to zero
    assign o_rs1_data = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
    assign o_rs2_data = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/exec_alu.sv
`default_nettype none

`include "cpu_params.svh"

module exec_alu import isa_pkg::*; (
    input  wire alu_op_e i_op,
    input  wire cond_e   i_cond,
    input  wire xword_t  i_a,
    input  wire xword_t  i_b,
    input  wire xword_t  i_pc,
    input  wire xword_t  i_imm,
    output xword_t       o_result,
    output logic         o_taken,
    output xword_t       o_target
);

    logic [`XLEN:0] diff;
    logic           eq;
    logic           lt;
    logic           ltu;

    // Shared subtractor with the borrow in the top bit
    assign diff = {1'b0, i_a} - {1'b0, i_b};
    assign eq   = (diff[`XLEN-1:0] == '0);
    assign ltu  = diff[`XLEN];
    assign lt   = (i_a[`XLEN-1] ^ i_b[`XLEN-1]) ? i_a[`XLEN-1] : diff[`XLEN-1];

    // Branch target adder
    assign o_target = i_pc + i_imm;

    always_comb begin
        unique case (i_cond)
            EQ:      o_taken = eq;
            NE:      o_taken = !eq;
            LT:      o_taken = lt;
            GE:      o_taken = !lt;
            LTU:     o_taken = ltu;
            GEU:     o_taken = !ltu;
            ALWAYS:  o_taken = 1'b1;
            default: o_taken = 1'b0;
        endcase
    end

    always_comb begin
        unique case (i_op)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = diff[`XLEN-1:0];
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_SLL:  o_result = i_a << i_b[4:0];
            ALU_SRL:  o_result = i_a >> i_b[4:0];
            ALU_SRA:  o_result = xword_t'($signed(i_a) >>> i_b[4:0]);
            ALU_SLT:  o_result = xword_t'(lt);
            ALU_SLTU: o_result = xword_t'(ltu);
            default:  o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/mul_unit.sv
`default_nettype none

`include "cpu_params.svh"

module mul_unit import isa_pkg::*; (
    input  wire logic   clk,
    input  wire logic   resetn,
    input  wire logic   i_start,
    input  wire xword_t i_a,
    input  wire xword_t i_b,
    output logic        o_busy,
    output logic        o_done,
    output xword_t      o_product
);

    xword_t                       mcand;
    xword_t                       mplier;
    xword_t                       acc;
    logic [$clog2(`XLEN+1)-1:0]   count;

    assign o_done    = o_busy && (count == '0);
    assign o_product = acc;

    // Multiplicand shifts up as the multiplier shifts down
    always_ff @(posedge clk) begin
        if (i_start) begin
            mcand  <= i_a;
            mplier <= i_b;
        end else if (o_busy && count != '0) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_busy <= 1'b0;
            count  <= '0;
            acc    <= '0;
        end else if (i_start) begin
            o_busy <= 1'b1;
            count  <= ($clog2(`XLEN+1))'(`XLEN);
            acc    <= '0;
        end else if (o_busy) begin
            if (count == '0) begin
                o_busy <= 1'b0;
            end else begin
                // One partial product per cycle
                if (mplier[0]) begin
                    acc <= acc + mcand;
                end
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/ex1_stage.sv
`default_nettype none

`include "cpu_params.svh"

module ex1_stage import isa_pkg::*, pipe_pkg::*; (
    input  wire logic           clk,
    input  wire logic           resetn,
    input  wire decoded_instr_t i_instr,
    input  wire logic           i_de_load,
    input  wire logic           i_de_clear,
    input  wire logic           i_ex1_load,
    input  wire logic           i_ex1_clear,
    input  wire byp_sel_e       i_byp_rs1,
    input  wire byp_sel_e       i_byp_rs2,
    input  wire xword_t         i_rf_rs1_data,
    input  wire xword_t         i_rf_rs2_data,
    input  wire xword_t         i_ex2_data,
    output reg_idx_t            o_rf_rs1_idx,
    output reg_idx_t            o_rf_rs2_idx,
    output decoded_instr_t      o_de_instr,
    output logic                o_de_valid,
    output ex1_out_t            o_ex1,
    output logic                o_ex1_valid,
    output logic                o_branch_taken,
    output xword_t              o_branch_target,
    output xword_t              o_npc
);

    xword_t rs1;
    xword_t rs2;
    xword_t op_b;
    xword_t alu_result;
    xword_t raw_target;
    logic   alu_taken;

    assign o_rf_rs1_idx = o_de_instr.rs1;
    assign o_rf_rs2_idx = o_de_instr.rs2;

    always_comb begin
        unique case (i_byp_rs1)
            BYP_EX1: rs1 = o_ex1.value;
            BYP_EX2: rs1 = i_ex2_data;
            default: rs1 = i_rf_rs1_data;
        endcase
        unique case (i_byp_rs2)
            BYP_EX1: rs2 = o_ex1.value;
            BYP_EX2: rs2 = i_ex2_data;
            default: rs2 = i_rf_rs2_data;
        endcase
    end

    // Branches always compare two registers
    assign op_b = (o_de_instr.use_imm && o_de_instr.op_type == OP_ALU) ? o_de_instr.imm : rs2;

    exec_alu u_alu (
        .i_op     (o_de_instr.alu_op),
        .i_cond   (o_de_instr.cond),
        .i_a      (rs1),
        .i_b      (op_b),
        .i_pc     (o_de_instr.pc),
        .i_imm    (o_de_instr.imm),
        .o_result (alu_result),
        .o_taken  (alu_taken),
        .o_target (raw_target)
    );

    assign o_npc           = o_de_instr.pc + 32'd4;
    assign o_branch_taken  = (o_de_instr.op_type == OP_BRANCH) && alu_taken;
    assign o_branch_target = {raw_target[`XLEN-1:1], 1'b0};

    always_ff @(posedge clk) begin
        if (i_de_load) begin
            o_de_instr <= i_instr;
        end
        if (i_ex1_load) begin
            o_ex1.op_type     <= o_de_instr.op_type;
            o_ex1.pc          <= o_de_instr.pc;
            o_ex1.rd          <= o_de_instr.rd;
            o_ex1.value2      <= rs2;
            o_ex1.value_valid <= (o_de_instr.op_type != OP_MUL);
            unique case (o_de_instr.op_type)
                OP_BRANCH: o_ex1.value <= o_npc;
                OP_MUL:    o_ex1.value <= rs1;
                default:   o_ex1.value <= alu_result;
            endcase
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_de_valid  <= 1'b0;
            o_ex1_valid <= 1'b0;
        end else begin
            if (i_de_load) begin
                o_de_valid <= 1'b1;
            end else if (i_de_clear) begin
                o_de_valid <= 1'b0;
            end
            if (i_ex1_load) begin
                o_ex1_valid <= 1'b1;
            end else if (i_ex1_clear) begin
                o_ex1_valid <= 1'b0;
            end
        end
    end

    a_ex1_load_clear: assert property (@(posedge clk) disable iff (!resetn)
        !(i_ex1_load && i_ex1_clear));

endmodule

`default_nettype wire

//--- hdl/ex2_stage.sv
`default_nettype none

module ex2_stage import isa_pkg::*, pipe_pkg::*; (
    input  wire logic     clk,
    input  wire logic     resetn,
    input  wire ex1_out_t i_ex1,
    input  wire logic     i_load,
    output logic          o_pending,
    output reg_idx_t      o_rd,
    output logic          o_done,
    output logic          o_wb_valid,
    output reg_idx_t      o_wb_rd,
    output xword_t        o_wb_data,
    output xword_t        o_wb_pc
);

    fu_sel_e fu_sel;
    xword_t  alu_data;
    xword_t  mul_product;
    logic    mul_start;
    logic    mul_busy;
    logic    mul_done;

    assign mul_start = i_load && (i_ex1.op_type == OP_MUL);

    mul_unit u_mul (
        .clk       (clk),
        .resetn    (resetn),
        .i_start   (mul_start),
        .i_a       (i_ex1.value),
        .i_b       (i_ex1.value2),
        .o_busy    (mul_busy),
        .o_done    (mul_done),
        .o_product (mul_product)
    );

    // Result valid for the instruction held here
    assign o_done     = o_pending && ((fu_sel == FU_MUL) ? mul_done : 1'b1);
    assign o_wb_valid = o_done;
    assign o_wb_rd    = o_rd;
    assign o_wb_data  = (fu_sel == FU_MUL) ? mul_product : alu_data;

    always_ff @(posedge clk) begin
        if (i_load) begin
            alu_data <= i_ex1.value;
            o_wb_pc  <= i_ex1.pc;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_pending <= 1'b0;
            o_rd      <= '0;
            fu_sel    <= FU_ALU;
        end else if (i_load) begin
            o_pending <= 1'b1;
            o_rd      <= i_ex1.rd;
            fu_sel    <= (i_ex1.op_type == OP_MUL) ? FU_MUL : FU_ALU;
        end else if (o_done) begin
            o_pending <= 1'b0;
            o_rd      <= '0;
            fu_sel    <= FU_ALU;
        end
    end

    a_no_load_busy: assert property (@(posedge clk) disable iff (!resetn)
        i_load |-> (!o_pending || o_done));

    // A new multiply may start in the cycle the previous one finishes
    a_mul_idle_start: assert property (@(posedge clk) disable iff (!resetn)
        mul_start |-> (!mul_busy || mul_done));

endmodule

`default_nettype wire

//--- hdl/issue_ctrl.sv
`default_nettype none

`include "cpu_params.svh"

module issue_ctrl import isa_pkg::*, pipe_pkg::*; (
    input  wire logic           clk,
    input  wire logic           resetn,
    input  wire logic           i_in_valid,
    input  wire logic           i_de_valid,
    input  wire decoded_instr_t i_de_instr,
    input  wire logic           i_ex1_valid,
    input  wire ex1_out_t       i_ex1,
    input  wire logic           i_ex2_pending,
    input  wire reg_idx_t       i_ex2_rd,
    input  wire logic           i_ex2_done,
    input  wire logic           i_branch_taken,
    input  wire xword_t         i_branch_target,
    input  wire xword_t         i_npc,
    output logic                o_in_ready,
    output logic                o_de_load,
    output logic                o_de_clear,
    output logic                o_ex1_load,
    output logic                o_ex1_clear,
    output logic                o_ex2_load,
    output byp_sel_e            o_byp_rs1,
    output byp_sel_e            o_byp_rs2,
    output logic                o_redirect_valid,
    output xword_t              o_redirect_pc
);

    ex_state_e state;
    xword_t    expected_pc;
    logic      stall_rs1;
    logic      stall_rs2;
    logic      ex2_ready;
    logic      de_fire;
    logic      pc_match;

    // Bypass source for one operand where EX1 holds the younger producer
    function automatic void pick_src(input reg_idx_t rs, output byp_sel_e sel,
                                     output logic stall);
        sel   = BYP_RF;
        stall = 1'b0;
        if (rs != '0) begin
            if (i_ex1_valid && i_ex1.rd == rs) begin
                sel   = BYP_EX1;
                stall = !i_ex1.value_valid;
            end else if (i_ex2_pending && i_ex2_rd == rs) begin
                sel   = BYP_EX2;
                stall = !i_ex2_done;
            end
        end
    endfunction

    always_comb begin
        pick_src(i_de_instr.rs1, o_byp_rs1, stall_rs1);
        pick_src(i_de_instr.rs2, o_byp_rs2, stall_rs2);
    end

    assign ex2_ready  = !i_ex2_pending || i_ex2_done;
    assign o_in_ready = !(i_de_valid && (stall_rs1 || stall_rs2))
                        && (!i_ex1_valid || ex2_ready);
    assign de_fire    = i_de_valid && o_in_ready;
    assign pc_match   = (i_de_instr.pc == expected_pc);

    assign o_de_load   = i_in_valid && o_in_ready;
    assign o_de_clear  = de_fire;
    assign o_ex1_load  = de_fire && pc_match;
    assign o_ex2_load  = i_ex1_valid && ex2_ready;
    // A squash also leaves EX1 empty since it needs EX1 free or draining
    assign o_ex1_clear = (o_ex2_load || de_fire) && !o_ex1_load;

    // Only the first squash after a good issue redirects
    assign o_redirect_valid = de_fire && !pc_match && (state == ST_NORMAL);
    assign o_redirect_pc    = expected_pc;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state       <= ST_NORMAL;
            expected_pc <= `RESET_PC;
        end else if (de_fire) begin
            state <= pc_match ? ST_NORMAL : ST_MISPREDICT;
            if (pc_match) begin
                expected_pc <= i_branch_taken ? i_branch_target : i_npc;
            end
        end
    end

    // Squashes after a redirect stay silent until the PC matches again
    a_redirect_one_shot: assert property (@(posedge clk) disable iff (!resetn)
        o_redirect_valid |=> !o_redirect_valid);

endmodule

`default_nettype wire

//--- hdl/cpu_backend.sv
`default_nettype none

module cpu_backend import isa_pkg::*, pipe_pkg::*; (
    input  wire logic           clk,
    input  wire logic           resetn,
    input  wire logic           i_instr_valid,
    input  wire decoded_instr_t i_instr,
    output logic                o_instr_ready,
    output logic                o_redirect_valid,
    output xword_t              o_redirect_pc,
    output logic                o_wb_valid,
    output reg_idx_t            o_wb_rd,
    output xword_t              o_wb_data,
    output xword_t              o_wb_pc
);

    decoded_instr_t de_instr;
    ex1_out_t       ex1;
    byp_sel_e       byp_rs1;
    byp_sel_e       byp_rs2;
    reg_idx_t       rs1_idx;
    reg_idx_t       rs2_idx;
    reg_idx_t       ex2_rd;
    xword_t         rs1_data;
    xword_t         rs2_data;
    xword_t         branch_target;
    xword_t         npc;
    logic           de_valid;
    logic           ex1_valid;
    logic           ex2_pending;
    logic           ex2_done;
    logic           branch_taken;
    logic           de_load;
    logic           de_clear;
    logic           ex1_load;
    logic           ex1_clear;
    logic           ex2_load;

    issue_ctrl u_ctrl (
        .clk              (clk),
        .resetn           (resetn),
        .i_in_valid       (i_instr_valid),
        .i_de_valid       (de_valid),
        .i_de_instr       (de_instr),
        .i_ex1_valid      (ex1_valid),
        .i_ex1            (ex1),
        .i_ex2_pending    (ex2_pending),
        .i_ex2_rd         (ex2_rd),
        .i_ex2_done       (ex2_done),
        .i_branch_taken   (branch_taken),
        .i_branch_target  (branch_target),
        .i_npc            (npc),
        .o_in_ready       (o_instr_ready),
        .o_de_load        (de_load),
        .o_de_clear       (de_clear),
        .o_ex1_load       (ex1_load),
        .o_ex1_clear      (ex1_clear),
        .o_ex2_load       (ex2_load),
        .o_byp_rs1        (byp_rs1),
        .o_byp_rs2        (byp_rs2),
        .o_redirect_valid (o_redirect_valid),
        .o_redirect_pc    (o_redirect_pc)
    );

    ex1_stage u_ex1 (
        .clk             (clk),
        .resetn          (resetn),
        .i_instr         (i_instr),
        .i_de_load       (de_load),
        .i_de_clear      (de_clear),
        .i_ex1_load      (ex1_load),
        .i_ex1_clear     (ex1_clear),
        .i_byp_rs1       (byp_rs1),
        .i_byp_rs2       (byp_rs2),
        .i_rf_rs1_data   (rs1_data),
        .i_rf_rs2_data   (rs2_data),
        .i_ex2_data      (o_wb_data),
        .o_rf_rs1_idx    (rs1_idx),
        .o_rf_rs2_idx    (rs2_idx),
        .o_de_instr      (de_instr),
        .o_de_valid      (de_valid),
        .o_ex1           (ex1),
        .o_ex1_valid     (ex1_valid),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target),
        .o_npc           (npc)
    );

    ex2_stage u_ex2 (
        .clk        (clk),
        .resetn     (resetn),
        .i_ex1      (ex1),
        .i_load     (ex2_load),
        .o_pending  (ex2_pending),
        .o_rd       (ex2_rd),
        .o_done     (ex2_done),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data),
        .o_wb_pc    (o_wb_pc)
    );

    reg_file u_rf (
        .clk        (clk),
        .resetn     (resetn),
        .i_rs1_idx  (rs1_idx),
        .i_rs2_idx  (rs2_idx),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_we       (o_wb_valid),
        .i_rd       (o_wb_rd),
        .i_wdata    (o_wb_data)
    );

endmodule

`default_nettype wire

//--- dv/tb_cpu_backend.sv
`default_nettype none

`include "cpu_params.svh"

module tb_cpu_backend import isa_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTR = 400;
    localparam int CLK_PERIOD = 10;

    typedef struct packed {
        reg_idx_t rd;
        xword_t   data;
        xword_t   pc;
    } wb_exp_t;

    logic           clk = 1'b0;
    logic           resetn;
    logic           i_instr_valid;
    decoded_instr_t i_instr;
    logic           o_instr_ready;
    logic           o_redirect_valid;
    xword_t         o_redirect_pc;
    logic           o_wb_valid;
    reg_idx_t       o_wb_rd;
    xword_t         o_wb_data;
    xword_t         o_wb_pc;

    integer         seed;
    int             err_count;
    int             sent;
    int             quiet;
    int             wb_count;
    int             redir_count;
    xword_t         fetch_pc;
    xword_t         exp_pc;
    logic           in_normal;
    xword_t         mregs [`NREGS];
    wb_exp_t        wb_q [$];
    xword_t         redir_q [$];
    logic           nxt_valid;
    decoded_instr_t nxt_instr;

    cpu_backend i_cpu_backend (
        .clk              (clk),
        .resetn           (resetn),
        .i_instr_valid    (i_instr_valid),
        .i_instr          (i_instr),
        .o_instr_ready    (o_instr_ready),
        .o_redirect_valid (o_redirect_valid),
        .o_redirect_pc    (o_redirect_pc),
        .o_wb_valid       (o_wb_valid),
        .o_wb_rd          (o_wb_rd),
        .o_wb_data        (o_wb_data),
        .o_wb_pc          (o_wb_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic xword_t alu_model(input alu_op_e op, input xword_t a, input xword_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return xword_t'($signed(a) >>> b[4:0]);
            ALU_SLT:  return xword_t'($signed(a) < $signed(b));
            ALU_SLTU: return xword_t'(a < b);
            default:  return '0;
        endcase
    endfunction

    function automatic logic cond_model(input cond_e c, input xword_t a, input xword_t b);
        case (c)
            EQ:      return a == b;
            NE:      return a != b;
            LT:      return $signed(a) < $signed(b);
            GE:      return $signed(a) >= $signed(b);
            LTU:     return a < b;
            GEU:     return a >= b;
            ALWAYS:  return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Issue or squash in handshake order as the DE/EX check does
    task automatic model_accept(input decoded_instr_t ins);
        xword_t a;
        xword_t b;
        xword_t res;
        logic   taken;
        a = mregs[ins.rs1];
        b = mregs[ins.rs2];
        taken = 1'b0;
        if (ins.pc != exp_pc) begin
            if (in_normal) begin
                redir_q.push_back(exp_pc);
            end
            in_normal = 1'b0;
        end else begin
            in_normal = 1'b1;
            case (ins.op_type)
                OP_MUL: res = a * b;
                OP_BRANCH: begin
                    res = ins.pc + 32'd4;
                    taken = cond_model(ins.cond, a, b);
                end
                default: res = alu_model(ins.alu_op, a, ins.use_imm ? ins.imm : b);
            endcase
            if (ins.rd != '0) begin
                mregs[ins.rd] = res;
            end
            wb_q.push_back('{rd: ins.rd, data: res, pc: ins.pc});
            exp_pc = taken ? ((ins.pc + ins.imm) & ~32'h1) : ins.pc + 32'd4;
        end
    endtask

    task automatic gen_instr(output decoded_instr_t ins);
        int unsigned r;
        r = $unsigned($random(seed)) % 100;
        ins = '0;
        ins.pc = fetch_pc;
        if (r < 60) begin
            ins.op_type = OP_ALU;
        end else if (r < 85) begin
            ins.op_type = OP_BRANCH;
        end else begin
            ins.op_type = OP_MUL;
        end
        ins.alu_op  = alu_op_e'($unsigned($random(seed)) % 10);
        ins.cond    = cond_e'($unsigned($random(seed)) % 7);
        // Few registers so that hazards are frequent
        ins.rs1     = reg_idx_t'($random(seed) & 7);
        ins.rs2     = reg_idx_t'($random(seed) & 7);
        ins.rd      = reg_idx_t'($random(seed) & 7);
        ins.use_imm = 1'($random(seed) & 1);
        if (ins.op_type == OP_BRANCH) begin
            // Short jumps including odd offsets
            ins.imm = xword_t'($unsigned($random(seed)) % 128) - 32'd64;
        end else begin
            ins.imm = $random(seed);
        end
    endtask

    task automatic report_mismatch(input string name, input xword_t got, input xword_t exp);
        err_count++;
        $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
    endtask

    task automatic check_writeback();
        wb_exp_t exp;
        assert (wb_q.size() != 0) else begin
            err_count++;
            $display("Writeback to x%0d at %0t with nothing expected", o_wb_rd, $time);
        end
        if (wb_q.size() != 0) begin
            exp = wb_q.pop_front();
            wb_count++;
            assert (o_wb_rd == exp.rd)
                else report_mismatch("o_wb_rd", xword_t'(o_wb_rd), xword_t'(exp.rd));
            assert (o_wb_data == exp.data) else report_mismatch("o_wb_data", o_wb_data, exp.data);
            assert (o_wb_pc == exp.pc) else report_mismatch("o_wb_pc", o_wb_pc, exp.pc);
        end
    endtask

    task automatic check_redirect();
        xword_t exp;
        assert (redir_q.size() != 0) else begin
            err_count++;
            $display("Redirect to 0x%h at %0t was not expected", o_redirect_pc, $time);
        end
        if (redir_q.size() != 0) begin
            exp = redir_q.pop_front();
            redir_count++;
            assert (o_redirect_pc == exp) else report_mismatch("o_redirect_pc", o_redirect_pc, exp);
        end
    endtask

    // Outputs are sampled at the falling edge before the handshake edge
    task automatic step_fetch();
        logic fire;
        fire = i_instr_valid && o_instr_ready;
        if (o_wb_valid) begin
            check_writeback();
        end
        if (o_redirect_valid) begin
            check_redirect();
        end
        if (fire) begin
            model_accept(i_instr);
            sent++;
            fetch_pc = fetch_pc + 32'd4;
        end
        if (o_redirect_valid) begin
            fetch_pc = o_redirect_pc;
        end
        if (fire || !i_instr_valid) begin
            nxt_valid = (sent < NUM_INSTR) && ($unsigned($random(seed)) % 5 != 0);
            if (nxt_valid) begin
                gen_instr(nxt_instr);
            end
        end
    endtask

    initial begin
        seed          = 32'hb692e529;
        resetn        = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        nxt_valid     = 1'b0;
        nxt_instr     = '0;
        err_count     = 0;
        sent          = 0;
        quiet         = 0;
        wb_count      = 0;
        redir_count   = 0;
        // Off the reset PC so the first instruction redirects
        fetch_pc      = `RESET_PC + 32'h100;
        exp_pc        = `RESET_PC;
        in_normal     = 1'b1;
        for (int i = 0; i < `NREGS; i++) begin
            mregs[i] = '0;
        end

        // Eight rising edges in reset
        repeat (7) begin
            @(negedge clk);
            assert (!o_wb_valid && !o_redirect_valid) else begin
                err_count++;
                $display("Writeback or redirect active during reset at %0t", $time);
            end
            assert (o_instr_ready) else begin
                err_count++;
                $display("Instruction ready low during reset at %0t", $time);
            end
        end
        @(posedge clk);
        #1;
        resetn = 1'b1;

        while (sent < NUM_INSTR || wb_q.size() != 0 || quiet < 20) begin
            @(negedge clk);
            step_fetch();
            if (sent >= NUM_INSTR && wb_q.size() == 0) begin
                quiet++;
            end
            @(posedge clk);
            #1;
            i_instr_valid = nxt_valid;
            i_instr       = nxt_instr;
        end

        assert (wb_q.size() == 0) else begin
            err_count++;
            $display("%0d expected writebacks never arrived", wb_q.size());
        end
        assert (redir_q.size() == 0) else begin
            err_count++;
            $display("%0d expected redirects never arrived", redir_q.size());
        end
        $display("Checked %0d writebacks and %0d redirects, %0d errors",
                 wb_count, redir_count, err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Slow multiplies bound the run length
    initial begin
        #(NUM_INSTR * (`XLEN + 10) * CLK_PERIOD);
        $display("Timeout after %0t with %0d instructions sent", $time, sent);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/reg_file.sv
hdl/exec_alu.sv
hdl/mul_unit.sv
hdl/ex1_stage.sv
hdl/ex2_stage.sv
hdl/issue_ctrl.sv
hdl/cpu_backend.sv
dv/tb_cpu_backend.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := tb_cpu_backend
RTL_TOP    := cpu_backend
FLIST      := compile.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "sim passed" > /dev/null

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
